// ==== Makefile ====
# Verilator build and run for the NNTP payload scanner

VERILATOR  ?= verilator
FILELIST   ?= src.f
TB_TOP     ?= tb_nntp_scan
RTL_TOP    ?= nntp_scan_top
OBJ_DIR    ?= obj_dir
TIMESCALE  ?= 1ns/10ps
VFLAGS     ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only -Wall

SRCS     := $(shell cat $(FILELIST))
RTL_SRCS := $(filter hdl/%,$(SRCS))
SIM_BIN  := $(OBJ_DIR)/V$(TB_TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --Mdir $(OBJ_DIR) \
		--top-module $(TB_TOP) -f $(FILELIST)

# Exit status of the simulation is the result of the run
run: $(SIM_BIN)
	./$(SIM_BIN)

lint:
	$(VERILATOR) $(LINT_FLAGS) --timescale $(TIMESCALE) \
		--top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(OBJ_DIR)

// ==== hdl/nids_pkg.sv ====
package nids_pkg;

   // Payload byte width
   localparam int BYTE_W = 8;

   // Stream number width and the number of streams it addresses
   localparam int STREAM_ID_W = 6;
   localparam int STREAM_COUNT = 1 << STREAM_ID_W;

   // Shared packet-match counter width
   localparam int COUNT_W = 16;

   // Matcher state width, also the width of one state memory entry
   localparam int STATE_W = 4;

   // Rule pattern, first character in the top byte
   localparam int PATTERN_LEN = 8;
   localparam logic [PATTERN_LEN*BYTE_W-1:0] PATTERN = "authinfo";

   // Bit that separates upper and lower case ASCII letters
   localparam logic [BYTE_W-1:0] CASE_BIT = 8'h20;

   typedef logic [BYTE_W-1:0]      byte_t;
   typedef logic [STREAM_ID_W-1:0] stream_id_t;

   // Wraps silently
   typedef logic [COUNT_W-1:0] match_count_t;

   // Number of pattern bytes seen so far, S_O is a complete match
   typedef enum logic [STATE_W-1:0] {
      S_IDLE, S_A, S_U, S_T, S_H, S_I, S_N, S_F, S_O
   } dfa_state_t;

   // Packet framing strobes with the stream they belong to
   typedef struct packed {
      logic       load_state;
      logic       eop;
      stream_id_t stream_id;
   } pkt_ctl_t;

   // One payload byte
   typedef struct packed {
      logic  vld;
      byte_t data;
   } char_beat_t;

   // Software write of one stream enable bit
   typedef struct packed {
      logic       wr;
      stream_id_t stream_id;
      logic       enable;
   } cfg_wr_t;

endpackage

// ==== hdl/nntp_dfa.sv ====
`timescale 1ns/10ps

module nntp_dfa import nids_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n,
   input  char_beat_t char_in,
   input  dfa_state_t state_in,
   input  logic       state_in_vld,
   output dfa_state_t state_out,
   output logic       accept
);

   // Byte after case folding
   byte_t folded;

   // Prefix length the incoming byte is compared against
   dfa_state_t base;

   // Next state and accept for the current byte
   dfa_state_t state_d;
   logic       accept_d;

   // Pattern character expected after pos bytes have matched
   function automatic byte_t pattern_byte(input dfa_state_t pos);
      int unsigned idx;
      idx = PATTERN_LEN - 1 - pos;
      return PATTERN[idx*BYTE_W +: BYTE_W];
   endfunction

   // ASCII upper case to lower case, other bytes pass unchanged
   function automatic byte_t to_lower(input byte_t c);
      byte_t r;
      r = c;
      if ((c >= "A") && (c <= "Z"))
         r = c | CASE_BIT;
      return r;
   endfunction

   always_comb
   begin
      folded = to_lower(char_in.data);
      // After a full match the next byte starts from an empty prefix
      base = (state_out == S_O) ? S_IDLE : state_out;
      accept_d = 1'b0;
      if (folded == pattern_byte(base))
      begin
         // Extend the prefix by one byte
         state_d = dfa_state_t'(base + STATE_W'(1));
         // Last character consumed, flag a match
         accept_d = (base == S_F);
      end
      else if (folded == pattern_byte(S_IDLE))
         // Mismatch on "a" already starts a new prefix
         state_d = S_A;
      else
         state_d = S_IDLE;
   end

   // State register, a load from the save memory wins over a beat
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         state_out <= S_IDLE;
         accept    <= 1'b0;
      end
      else if (state_in_vld)
      begin
         state_out <= state_in;
         accept    <= 1'b0;
      end
      else if (char_in.vld)
      begin
         state_out <= state_d;
         // One-cycle pulse after the completing byte
         accept    <= accept_d;
      end
      else
      begin
         accept <= 1'b0;
      end
   end

endmodule

// ==== hdl/nntp_scan_top.sv ====
`timescale 1ns/10ps

module nntp_scan_top import nids_pkg::*;
(
   input  logic         clk,
   input  logic         rst_n,
   input  pkt_ctl_t     pkt,
   input  char_beat_t   beat,
   input  cfg_wr_t      cfg,
   output match_count_t match_count,
   output logic         fired
);

   // Lookups for the stream on the packet bus
   logic enable;
   logic new_stream;

   // Stream marked as seen at an enabled eop
   logic commit;

   // Matcher state load path and result
   dfa_state_t state_in;
   logic       state_in_vld;
   dfa_state_t state_out;
   logic       accept;

   // Per-stream enable and seen bits
   stream_ctx_regs i_stream_ctx_regs (
      .clk        (clk),
      .rst_n      (rst_n),
      .cfg        (cfg),
      .stream_id  (pkt.stream_id),
      .commit     (commit),
      .enable     (enable),
      .new_stream (new_stream)
   );

   // Save/restore memory, match flag and counter
   rule_slot i_rule_slot (
      .clk          (clk),
      .rst_n        (rst_n),
      .pkt          (pkt),
      .enable       (enable),
      .new_stream   (new_stream),
      .state_out    (state_out),
      .accept       (accept),
      .state_in     (state_in),
      .state_in_vld (state_in_vld),
      .commit       (commit),
      .match_count  (match_count),
      .fired        (fired)
   );

   // Pattern automaton on the payload beats
   nntp_dfa i_nntp_dfa (
      .clk          (clk),
      .rst_n        (rst_n),
      .char_in      (beat),
      .state_in     (state_in),
      .state_in_vld (state_in_vld),
      .state_out    (state_out),
      .accept       (accept)
   );

endmodule

// ==== hdl/rule_slot.sv ====
`timescale 1ns/10ps

module rule_slot import nids_pkg::*;
(
   input  logic         clk,
   input  logic         rst_n,
   input  pkt_ctl_t     pkt,
   input  logic         enable,
   input  logic         new_stream,
   input  dfa_state_t   state_out,
   input  logic         accept,
   output dfa_state_t   state_in,
   output logic         state_in_vld,
   output logic         commit,
   output match_count_t match_count,
   output logic         fired
);

   // Matcher progress saved at the end of each enabled packet
   dfa_state_t state_mem [STREAM_COUNT];

   // End of a packet on an enabled stream
   assign commit = pkt.eop & enable;

   // State save
   always_ff @(posedge clk)
   begin
      if (commit)
      begin
         // Lets a pattern span two packets of one stream
         state_mem[pkt.stream_id] <= state_out;
      end
   end

   // State restore at packet start
   always_ff @(posedge clk)
   begin
      if (pkt.load_state)
      begin
         // New stream starts from the empty prefix
         if (new_stream)
            state_in <= S_IDLE;
         else
            state_in <= state_mem[pkt.stream_id];
      end
   end

   // Load strobe to the matcher, one cycle after load_state
   always_ff @(posedge clk)
   begin
      if (!rst_n)
         state_in_vld <= 1'b0;
      else
         state_in_vld <= pkt.load_state;
   end

   // Per-packet match flag and the shared counter
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         match_count <= '0;
         fired       <= 1'b0;
      end
      else
      begin
         // Fresh packet, nothing matched yet
         if (pkt.load_state)
            fired <= 1'b0;

         // Any occurrence in the packet sets the flag
         if (accept)
            fired <= 1'b1;

         if (commit)
         begin
            // At most one count per packet
            match_count <= match_count + match_count_t'(fired);
         end
         else if (pkt.eop)
         begin
            // Disabled stream, the match is dropped
            fired <= 1'b0;
         end
      end
   end

endmodule

// ==== hdl/stream_ctx_regs.sv ====
`timescale 1ns/10ps

module stream_ctx_regs import nids_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n,
   input  cfg_wr_t    cfg,
   input  stream_id_t stream_id,
   input  logic       commit,
   output logic       enable,
   output logic       new_stream
);

   // Rule enable per stream, written by software
   logic [STREAM_COUNT-1:0] enable_bits;

   // Set once a stream has saved matcher state
   logic [STREAM_COUNT-1:0] seen_bits;

   // Enable bitmap
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         // All streams start disabled
         enable_bits <= '0;
      end
      else if (cfg.wr)
      begin
         // Write lands on the next edge
         enable_bits[cfg.stream_id] <= cfg.enable;
      end
   end

   // Seen bitmap
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         // Every stream is new again after reset
         seen_bits <= '0;
      end
      else if (commit)
      begin
         // State was just saved for this stream
         seen_bits[stream_id] <= 1'b1;
      end
   end

   // Lookups for the stream on the packet bus
   always_comb
   begin
      enable = enable_bits[stream_id];
      // No saved state yet, the matcher must start empty
      new_stream = ~seen_bits[stream_id];
   end

endmodule

// ==== src.f ====
hdl/nids_pkg.sv
hdl/nntp_dfa.sv
hdl/stream_ctx_regs.sv
hdl/rule_slot.sv
hdl/nntp_scan_top.sv
verification/tb_nntp_scan.sv

// ==== verification/nntp_scan_trace.txt ====
# R reset, C <stream> <enable>, S <stream> packet start, E packet end, N <count hex>, F <fired>
# B <bytes> where _ is a space and ~ an idle cycle
N 0000
F 0
# One match in one packet
C 1 1
S 1
B AuthInfo_user
F 1
E
N 0001
F 1
S 1
F 0
B group_~~misc
E
N 0001
F 0
# Two matches in one packet count once
C 2 1
S 2
B authinfoauthinfo
F 1
E
N 0002
S 2
B xAUTHINFO_pass_~AuthInfo
E
N 0003
# Pattern split over two packets of stream 3, stream 9 in between
C 3 1
C 9 1
S 3
B some_auth
F 0
E
N 0003
S 9
B info_only
F 0
E
N 0003
S 3
B info
F 1
E
N 0004
# Disabled stream adds nothing and saves nothing
S 5
B authinfo
F 1
E
F 0
N 0004
S 5
B xx_auth
E
N 0004
C 5 1
S 5
B info
F 0
E
N 0004
S 5
B AUTH
E
S 5
B ~INFO
F 1
E
N 0005
C 2 0
S 2
B authinfo
E
F 0
N 0005
# Stream 3 left half way through the pattern
S 3
B auth
E
N 0005
# Reset clears the count, the enables and the saved context
R
N 0000
F 0
S 1
B authinfo
E
N 0000
C 1 1
S 1
B authinfo
E
N 0001
C 3 1
S 3
B info
F 0
E
N 0001

// ==== verification/tb_nntp_scan.sv ====
`timescale 1ns/10ps

module tb_nntp_scan import nids_pkg::*;
();

   localparam int RESET_CYCLES = 16;
   // Longest wait for any spacing rule in clock cycles
   localparam int WAIT_LIMIT = 64;
   // Upper bound on trace lines read
   localparam int LINE_LIMIT = 10000;
   localparam string TRACE_FILE = "verification/nntp_scan_trace.txt";

   logic         clk;
   logic         rst_n;
   pkt_ctl_t     pkt;
   char_beat_t   beat;
   cfg_wr_t      cfg;
   match_count_t match_count;
   logic         fired;

   // Rising edges since time zero
   int cyc;
   // Rising edges that sampled the latest strobe of each kind
   int load_edge;
   int beat_edge;
   int eop_edge;
   int checks_done;

   nntp_scan_top i_nntp_scan_top (
      .clk         (clk),
      .rst_n       (rst_n),
      .pkt         (pkt),
      .beat        (beat),
      .cfg         (cfg),
      .match_count (match_count),
      .fired       (fired)
   );

   // 10 ns clock
   always #5 clk = ~clk;

   always @(posedge clk)
      cyc <= cyc + 1;

   task automatic stop_on_error(input string why);
      $display("%s", why);
      $display("Regression failed");
      $fatal(1, "first error reached");
   endtask

   // Step falling edges until the next rising edge lies gap edges after mark
   task automatic wait_gap(input int mark, input int gap);
      int n;
      n = 0;
      while (cyc + 1 < mark + gap)
      begin
         if (n >= WAIT_LIMIT)
            stop_on_error("A spacing wait did not finish within its limit");
         else
         begin
            @(negedge clk);
            n++;
         end
      end
   endtask

   task automatic apply_reset();
      int n;
      rst_n = 1'b0;
      pkt   = '0;
      beat  = '0;
      cfg   = '0;
      n = 0;
      // Sixteen rising edges with reset low
      while (n < RESET_CYCLES)
      begin
         @(negedge clk);
         n++;
      end
      rst_n     = 1'b1;
      load_edge = cyc;
      beat_edge = cyc;
      eop_edge  = cyc;
   endtask

   task automatic write_cfg(input int sid, input int en);
      cfg.wr        = 1'b1;
      cfg.stream_id = stream_id_t'(sid);
      cfg.enable    = en[0];
      @(negedge clk);
      cfg.wr = 1'b0;
   endtask

   task automatic start_packet(input int sid);
      // Next packet at least one cycle after eop
      wait_gap(eop_edge, 1);
      pkt.load_state = 1'b1;
      // Stream ID stays on the bus until the next packet
      pkt.stream_id  = stream_id_t'(sid);
      load_edge      = cyc + 1;
      @(negedge clk);
      pkt.load_state = 1'b0;
   endtask

   // Bytes follow the kind letter and a space
   task automatic send_bytes(input string line);
      int  i;
      byte c;
      for (i = 2; i < line.len(); i++)
      begin
         c = line.getc(i);
         if ((c == " ") || (c == "\n") || (c == 8'h0d) || (c == "\t"))
            break;
         if (c == "~")
         begin
            // Idle cycle inside the packet
            beat.vld = 1'b0;
         end
         else
         begin
            // First beat two cycles after load_state
            wait_gap(load_edge, 2);
            beat.vld  = 1'b1;
            // Underscore stands for a space
            beat.data = (c == "_") ? 8'h20 : byte_t'(c);
            beat_edge = cyc + 1;
         end
         @(negedge clk);
      end
      beat.vld = 1'b0;
   endtask

   task automatic end_packet();
      // Leaves room for accept to reach fired
      wait_gap(beat_edge, 2);
      wait_gap(load_edge, 1);
      pkt.eop  = 1'b1;
      eop_edge = cyc + 1;
      @(negedge clk);
      pkt.eop = 1'b0;
   endtask

   task automatic check_count(input match_count_t expected);
      // Count is valid one cycle after the eop edge
      wait_gap(eop_edge, 1);
      checks_done++;
      if (match_count !== expected)
         stop_on_error($sformatf("ERR %0t match_count got %h expected %h",
                                 $time, match_count, expected));
   endtask

   task automatic check_fired(input logic expected);
      // Settled after the last byte, load_state and eop
      wait_gap(beat_edge, 2);
      wait_gap(load_edge, 1);
      wait_gap(eop_edge, 1);
      checks_done++;
      if (fired !== expected)
         stop_on_error($sformatf("ERR %0t fired got %b expected %b",
                                 $time, fired, expected));
   endtask

   initial
   begin
      int    fd;
      int    lines;
      int    n;
      int    a;
      int    b;
      byte   code;
      string line;
      clk         = 1'b0;
      rst_n       = 1'b0;
      pkt         = '0;
      beat        = '0;
      cfg         = '0;
      cyc         = 0;
      load_edge   = 0;
      beat_edge   = 0;
      eop_edge    = 0;
      checks_done = 0;
      lines       = 0;
      apply_reset();
      fd = $fopen(TRACE_FILE, "r");
      if (fd == 0)
         stop_on_error("The trace file could not be opened");
      while ($fgets(line, fd) != 0)
      begin
         lines++;
         if (lines > LINE_LIMIT)
            stop_on_error("The trace file is longer than the line limit");
         code = (line.len() > 0) ? line.getc(0) : "#";
         case (code)
            // Comment or blank line
            "#", "\n", 8'h0d: ;
            "R": apply_reset();
            "C":
            begin
               n = $sscanf(line.substr(1, line.len() - 1), "%d %d", a, b);
               if (n != 2)
                  stop_on_error($sformatf("Bad configuration line: %s", line));
               else
                  write_cfg(a, b);
            end
            "S":
            begin
               n = $sscanf(line.substr(1, line.len() - 1), "%d", a);
               if (n != 1)
                  stop_on_error($sformatf("Bad packet start line: %s", line));
               else
                  start_packet(a);
            end
            "B": send_bytes(line);
            "E": end_packet();
            "N":
            begin
               n = $sscanf(line.substr(1, line.len() - 1), "%h", a);
               if (n != 1)
                  stop_on_error($sformatf("Bad count line: %s", line));
               else
                  check_count(match_count_t'(a));
            end
            "F":
            begin
               n = $sscanf(line.substr(1, line.len() - 1), "%d", a);
               if (n != 1)
                  stop_on_error($sformatf("Bad fired line: %s", line));
               else
                  check_fired(a[0]);
            end
            default: stop_on_error($sformatf("Unknown trace line: %s", line));
         endcase
      end
      $fclose(fd);
      if (checks_done > 0)
      begin
         $display("Regression passed");
         $finish;
      end
      else
      begin
         stop_on_error("The trace file held no checks");
      end
   end

endmodule
